// File: src/decoding_graph_pkg.sv
package decoding_graph_pkg;

    typedef enum logic [1:0] {
        STAGE_IDLE                = 2'd0,
        STAGE_MEASUREMENT_LOADING = 2'd1,
        STAGE_GROW                = 2'd2
    } stage_e;

    typedef enum logic [1:0] {
        LINK_NS = 2'd0,
        LINK_EW = 2'd1,
        LINK_UD = 2'd2
    } link_family_e;

    localparam int WEIGHT_WIDTH_MAX = 4;
    localparam int NEIGHBOR_COUNT   = 6;
    localparam int NO_UNIT          = -1;  // Link has no second end

    // Neighbor directions as seen from a unit
    localparam int DIR_NORTH = 0;
    localparam int DIR_SOUTH = 1;
    localparam int DIR_WEST  = 2;
    localparam int DIR_EAST  = 3;
    localparam int DIR_DOWN  = 4;
    localparam int DIR_UP    = 5;

    typedef struct packed {
        link_family_e                family;
        logic [WEIGHT_WIDTH_MAX-1:0] value;
    } weight_write_t;

    typedef struct packed {
        logic [WEIGHT_WIDTH_MAX-1:0] ns;
        logic [WEIGHT_WIDTH_MAX-1:0] ew;
        logic [WEIGHT_WIDTH_MAX-1:0] ud;
    } weight_cfg_t;

    // NS link n sits under row n+1, its a end is the unit above (south side)
    function automatic int ns_link_a(input int link, input int width_x);
        return (link < width_x - 1) ? link : NO_UNIT;
    endfunction

    function automatic int ns_link_b(input int link, input int width_x);
        return (link % 2 == 0 && link + 1 < width_x) ? link + 1 : NO_UNIT;
    endfunction

    // Last EW link is the east boundary of the bottom row
    function automatic int ew_link_a(input int link, input int width_x);
        if (link == width_x - 1 || link % 2 == 0) begin
            return link;
        end
        return link + 1;  // Internal, east side of the lower unit
    endfunction

    function automatic int ew_link_b(input int link, input int width_x);
        return (link % 2 == 1 && link < width_x - 1) ? link : NO_UNIT;
    endfunction

    function automatic int ew_a_dir(input int link, input int width_x);
        return (link % 2 == 0 && link != width_x - 1) ? DIR_WEST : DIR_EAST;
    endfunction

    function automatic logic [NEIGHBOR_COUNT-1:0] neighbor_mask(
        input int row,
        input int layer,
        input int width_x,
        input int width_u
    );
        logic [NEIGHBOR_COUNT-1:0] mask;
        mask = '0;
        for (int n = 0; n < width_x - 1; n++) begin
            if (ns_link_a(n, width_x) == row) begin
                mask[DIR_SOUTH] = 1'b1;
            end
            if (ns_link_b(n, width_x) == row) begin
                mask[DIR_NORTH] = 1'b1;
            end
        end
        for (int n = 0; n < width_x; n++) begin
            if (ew_link_a(n, width_x) == row) begin
                mask[ew_a_dir(n, width_x)] = 1'b1;
            end
            if (ew_link_b(n, width_x) == row) begin
                mask[DIR_WEST] = 1'b1;
            end
        end
        mask[DIR_DOWN] = 1'b1;                  // Real boundary below round 0
        mask[DIR_UP]   = (layer < width_u - 1);  // Nothing above the top round
        return mask;
    endfunction

endpackage

// File: src/graph_config.sv
`timescale 1ns/100ps

module graph_config
    import decoding_graph_pkg::*;
#(
    parameter int MAX_WEIGHT = 3
) (
    input  logic          clk,
    input  logic          reset,
    input  stage_e        stage_i,
    input  logic          weight_wr_i,
    input  weight_write_t weight_wr_data_i,
    output logic          load_o,
    output logic          grow_o,
    output weight_cfg_t   weights_o
);

    localparam int WEIGHT_WIDTH = $clog2(MAX_WEIGHT + 1);
    localparam logic [WEIGHT_WIDTH-1:0] WEIGHT_RESET = WEIGHT_WIDTH'(2);

    stage_e                  stage_q;
    logic [WEIGHT_WIDTH-1:0] ns_weight_q;
    logic [WEIGHT_WIDTH-1:0] ew_weight_q;
    logic [WEIGHT_WIDTH-1:0] ud_weight_q;
    logic [WEIGHT_WIDTH-1:0] wr_value;

    assign wr_value = weight_wr_data_i.value[WEIGHT_WIDTH-1:0];  // Upper bits dropped

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= STAGE_IDLE;
        end else begin
            stage_q <= stage_i;
        end
    end

    // Weights only change between decodes
    always_ff @(posedge clk) begin
        if (reset) begin
            ns_weight_q <= WEIGHT_RESET;
            ew_weight_q <= WEIGHT_RESET;
            ud_weight_q <= WEIGHT_RESET;
        end else if (weight_wr_i && stage_q == STAGE_IDLE) begin
            case (weight_wr_data_i.family)
                LINK_NS: ns_weight_q <= wr_value;
                LINK_EW: ew_weight_q <= wr_value;
                LINK_UD: ud_weight_q <= wr_value;
                default: ;  // Unknown family, write dropped
            endcase
        end
    end

    assign load_o = (stage_q == STAGE_MEASUREMENT_LOADING);
    assign grow_o = (stage_q == STAGE_GROW);

    assign weights_o.ns = WEIGHT_WIDTH_MAX'(ns_weight_q);
    assign weights_o.ew = WEIGHT_WIDTH_MAX'(ew_weight_q);
    assign weights_o.ud = WEIGHT_WIDTH_MAX'(ud_weight_q);

endmodule

// File: src/processing_unit.sv
`timescale 1ns/100ps

module processing_unit
    import decoding_graph_pkg::*;
#(
    parameter logic [NEIGHBOR_COUNT-1:0] PRESENT_NEIGHBORS = '1
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load_i,
    input  logic                      measurement_i,
    output logic                      defect_o,
    input  logic [NEIGHBOR_COUNT-1:0] neighbor_grown_i,
    output logic                      busy_o
);

    logic                      defect_q;
    logic [NEIGHBOR_COUNT-1:0] open_links;

    // Each load pulls in the round from the layer above
    always_ff @(posedge clk) begin
        if (reset) begin
            defect_q <= 1'b0;
        end else if (load_i) begin
            defect_q <= measurement_i;
        end
    end

    assign defect_o = defect_q;

    // Absent directions are masked, their inputs may float
    assign open_links = PRESENT_NEIGHBORS & ~neighbor_grown_i;
    assign busy_o     = defect_q & (|open_links);

endmodule

// File: src/neighbor_link.sv
`timescale 1ns/100ps

module neighbor_link #(
    parameter int WEIGHT_WIDTH = 2,
    parameter bit IS_BOUNDARY  = 1'b0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_i,
    input  logic                    grow_i,
    input  logic [WEIGHT_WIDTH-1:0] weight_i,
    input  logic                    a_increase_i,
    input  logic                    b_increase_i,
    output logic                    grown_o
);

    localparam int SUM_WIDTH = WEIGHT_WIDTH + 1;

    logic [WEIGHT_WIDTH-1:0] growth_q;
    logic [1:0]              step;
    logic [SUM_WIDTH-1:0]    growth_sum;

    if (IS_BOUNDARY) begin : g_single
        assign step = {1'b0, a_increase_i};  // Only the a end exists
    end else begin : g_pair
        assign step = {1'b0, a_increase_i} + {1'b0, b_increase_i};
    end

    assign growth_sum = {1'b0, growth_q} + SUM_WIDTH'(step);

    always_ff @(posedge clk) begin
        if (reset) begin
            growth_q <= '0;
        end else if (load_i) begin
            growth_q <= '0;  // New round restarts growth
        end else if (grow_i) begin
            if (growth_sum >= SUM_WIDTH'(weight_i)) begin
                growth_q <= weight_i;  // Saturate
            end else begin
                growth_q <= growth_sum[WEIGHT_WIDTH-1:0];
            end
        end
    end

    assign grown_o = (growth_q >= weight_i);

endmodule

// File: src/decoding_graph.sv
`timescale 1ns/100ps

module decoding_graph
    import decoding_graph_pkg::*;
#(
    parameter int  GRID_WIDTH_X = 4,
    parameter int  GRID_WIDTH_U = 3,
    parameter int  MAX_WEIGHT   = 3,
    localparam int PU_COUNT     = GRID_WIDTH_X * GRID_WIDTH_U,
    localparam int NS_PER_ROUND = GRID_WIDTH_X - 1,
    localparam int EW_PER_ROUND = GRID_WIDTH_X,
    localparam int UD_PER_ROUND = GRID_WIDTH_X
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [GRID_WIDTH_X-1:0] measurements_i,
    input  stage_e                  stage_i,
    input  logic                    weight_wr_i,
    input  weight_write_t           weight_wr_data_i,
    output logic [PU_COUNT-1:0]     busy_o,
    output logic [(NS_PER_ROUND+EW_PER_ROUND+UD_PER_ROUND)*GRID_WIDTH_U-1:0] link_grown_o
);

    localparam int WEIGHT_WIDTH = $clog2(MAX_WEIGHT + 1);

    typedef struct packed {
        logic [NS_PER_ROUND*GRID_WIDTH_U-1:0] ns;
        logic [EW_PER_ROUND*GRID_WIDTH_U-1:0] ew;
        logic [UD_PER_ROUND*GRID_WIDTH_U-1:0] ud;
    } link_grown_t;

    link_grown_t                        link_grown;
    logic                               load;
    logic                               grow;
    weight_cfg_t                        weights;
    logic [WEIGHT_WIDTH-1:0]            ns_weight;
    logic [WEIGHT_WIDTH-1:0]            ew_weight;
    logic [WEIGHT_WIDTH-1:0]            ud_weight;
    logic [PU_COUNT-1:0]                defect;
    logic [PU_COUNT*NEIGHBOR_COUNT-1:0] neighbor_grown;  // Six bits per unit

    assign link_grown_o = link_grown;

    graph_config #(
        .MAX_WEIGHT(MAX_WEIGHT)
    ) graph_config_inst (
        .clk             (clk),
        .reset           (reset),
        .stage_i         (stage_i),
        .weight_wr_i     (weight_wr_i),
        .weight_wr_data_i(weight_wr_data_i),
        .load_o          (load),
        .grow_o          (grow),
        .weights_o       (weights)
    );

    assign ns_weight = weights.ns[WEIGHT_WIDTH-1:0];
    assign ew_weight = weights.ew[WEIGHT_WIDTH-1:0];
    assign ud_weight = weights.ud[WEIGHT_WIDTH-1:0];

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : pu_k
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : pu_i
            localparam int UNIT = i + k * GRID_WIDTH_X;
            logic measurement;

            if (k == GRID_WIDTH_U - 1) begin : g_top
                assign measurement = measurements_i[i];  // Newest round
            end else begin : g_shift
                assign measurement = defect[UNIT + GRID_WIDTH_X];
            end

            processing_unit #(
                .PRESENT_NEIGHBORS(neighbor_mask(i, k, GRID_WIDTH_X, GRID_WIDTH_U))
            ) processing_unit_inst (
                .clk             (clk),
                .reset           (reset),
                .load_i          (load),
                .measurement_i   (measurement),
                .defect_o        (defect[UNIT]),
                .neighbor_grown_i(neighbor_grown[UNIT*NEIGHBOR_COUNT +: NEIGHBOR_COUNT]),
                .busy_o          (busy_o[UNIT])
            );
        end
    end

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : ns_k
        for (genvar n = 0; n < NS_PER_ROUND; n++) begin : ns_n
            localparam int A     = ns_link_a(n, GRID_WIDTH_X) + k * GRID_WIDTH_X;
            localparam int B_ROW = ns_link_b(n, GRID_WIDTH_X);
            logic grown;

            assign link_grown.ns[n + k * NS_PER_ROUND]       = grown;
            assign neighbor_grown[A * NEIGHBOR_COUNT + DIR_SOUTH] = grown;

            if (B_ROW == NO_UNIT) begin : g_boundary
                neighbor_link #(.WEIGHT_WIDTH(WEIGHT_WIDTH), .IS_BOUNDARY(1'b1)) link_inst (
                    .clk(clk), .reset(reset), .load_i(load), .grow_i(grow),
                    .weight_i(ns_weight), .a_increase_i(defect[A]),
                    .b_increase_i(), .grown_o(grown)
                );
            end else begin : g_internal
                localparam int B = B_ROW + k * GRID_WIDTH_X;
                assign neighbor_grown[B * NEIGHBOR_COUNT + DIR_NORTH] = grown;
                neighbor_link #(.WEIGHT_WIDTH(WEIGHT_WIDTH), .IS_BOUNDARY(1'b0)) link_inst (
                    .clk(clk), .reset(reset), .load_i(load), .grow_i(grow),
                    .weight_i(ns_weight), .a_increase_i(defect[A]),
                    .b_increase_i(defect[B]), .grown_o(grown)
                );
            end
        end
    end

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : ew_k
        for (genvar n = 0; n < EW_PER_ROUND; n++) begin : ew_n
            localparam int A     = ew_link_a(n, GRID_WIDTH_X) + k * GRID_WIDTH_X;
            localparam int B_ROW = ew_link_b(n, GRID_WIDTH_X);
            logic grown;

            assign link_grown.ew[n + k * EW_PER_ROUND] = grown;
            assign neighbor_grown[A * NEIGHBOR_COUNT + ew_a_dir(n, GRID_WIDTH_X)] = grown;

            if (B_ROW == NO_UNIT) begin : g_boundary
                neighbor_link #(.WEIGHT_WIDTH(WEIGHT_WIDTH), .IS_BOUNDARY(1'b1)) link_inst (
                    .clk(clk), .reset(reset), .load_i(load), .grow_i(grow),
                    .weight_i(ew_weight), .a_increase_i(defect[A]),
                    .b_increase_i(), .grown_o(grown)
                );
            end else begin : g_internal
                localparam int B = B_ROW + k * GRID_WIDTH_X;
                assign neighbor_grown[B * NEIGHBOR_COUNT + DIR_WEST] = grown;
                neighbor_link #(.WEIGHT_WIDTH(WEIGHT_WIDTH), .IS_BOUNDARY(1'b0)) link_inst (
                    .clk(clk), .reset(reset), .load_i(load), .grow_i(grow),
                    .weight_i(ew_weight), .a_increase_i(defect[A]),
                    .b_increase_i(defect[B]), .grown_o(grown)
                );
            end
        end
    end

    // UD link k joins round k (down side) to round k-1 (up side)
    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : ud_k
        for (genvar i = 0; i < UD_PER_ROUND; i++) begin : ud_i
            localparam int A = i + k * GRID_WIDTH_X;
            logic grown;

            assign link_grown.ud[i + k * UD_PER_ROUND]         = grown;
            assign neighbor_grown[A * NEIGHBOR_COUNT + DIR_DOWN] = grown;

            if (k == 0) begin : g_boundary
                neighbor_link #(.WEIGHT_WIDTH(WEIGHT_WIDTH), .IS_BOUNDARY(1'b1)) link_inst (
                    .clk(clk), .reset(reset), .load_i(load), .grow_i(grow),
                    .weight_i(ud_weight), .a_increase_i(defect[A]),
                    .b_increase_i(), .grown_o(grown)
                );
            end else begin : g_internal
                localparam int B = A - GRID_WIDTH_X;
                assign neighbor_grown[B * NEIGHBOR_COUNT + DIR_UP] = grown;
                neighbor_link #(.WEIGHT_WIDTH(WEIGHT_WIDTH), .IS_BOUNDARY(1'b0)) link_inst (
                    .clk(clk), .reset(reset), .load_i(load), .grow_i(grow),
                    .weight_i(ud_weight), .a_increase_i(defect[A]),
                    .b_increase_i(defect[B]), .grown_o(grown)
                );
            end
        end
    end

endmodule

// File: dv/decoding_graph_chk.sv
`timescale 1ns/100ps

module decoding_graph_chk #(
    parameter int LINK_COUNT = 33
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  load_i,
    input logic                  grow_i,
    input logic [LINK_COUNT-1:0] link_grown_i
);

    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(load_i && grow_i))
        else $error("load and grow strobes are high in the same cycle");

    strobes_low_after_reset: assert property (@(posedge clk)
        reset |=> (!load_i && !grow_i))
        else $error("a strobe is high in the cycle after reset");

    // Growth is cleared only by a load
    grown_falls_on_load: assert property (@(posedge clk) disable iff (reset)
        (|($past(link_grown_i) & ~link_grown_i)) |-> $past(load_i))
        else $error("a grown link fell without a load");

endmodule

bind decoding_graph decoding_graph_chk #(
    .LINK_COUNT((3 * GRID_WIDTH_X - 1) * GRID_WIDTH_U)
) decoding_graph_chk_inst (
    .clk         (clk),
    .reset       (reset),
    .load_i      (load),
    .grow_i      (grow),
    .link_grown_i(link_grown_o)
);

// File: dv/decoding_graph_tb.sv
`timescale 1ns/100ps

module decoding_graph_tb
    import decoding_graph_pkg::*;
();

    localparam int GRID_WIDTH_X  = 4;
    localparam int GRID_WIDTH_U  = 3;
    localparam int PU_COUNT      = GRID_WIDTH_X * GRID_WIDTH_U;
    localparam int NS_LINKS      = (GRID_WIDTH_X - 1) * GRID_WIDTH_U;
    localparam int EW_LINKS      = GRID_WIDTH_X * GRID_WIDTH_U;
    localparam int UD_LINKS      = GRID_WIDTH_X * GRID_WIDTH_U;
    localparam int LINK_BITS     = NS_LINKS + EW_LINKS + UD_LINKS;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_LEN     = 3;
    localparam int SETTLE_CYCLES = 3;  // Covers the two-edge latency
    localparam logic [31:0] LFSR_SEED = 32'h36e4e16c;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int TEST_CYCLES = RESET_LEN + 1
        + (3 + 1 + SETTLE_CYCLES)
        + (2 + SETTLE_CYCLES)
        + (3 + 1 + SETTLE_CYCLES) + 3 + (3 + SETTLE_CYCLES)
        + 2 + (1 + 1 + SETTLE_CYCLES) + (1 + SETTLE_CYCLES);
    localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

    typedef struct packed {
        logic [PU_COUNT-1:0] defects;
        weight_cfg_t         weights;
        logic [7:0]          grows;  // Grow cycles since the last load
    } ref_state_t;

    typedef struct packed {
        logic [PU_COUNT-1:0]  busy;
        logic [LINK_BITS-1:0] grown;
    } expected_t;

    logic                    clk;
    logic                    reset;
    logic [GRID_WIDTH_X-1:0] measurements;
    stage_e                  stage;
    logic                    weight_wr;
    weight_write_t           weight_wr_data;
    logic [PU_COUNT-1:0]     busy;
    logic [LINK_BITS-1:0]    link_grown;  // ns, ew, ud from the top bits down

    ref_state_t  ref_state;
    stage_e      ref_stage_q;
    logic [1:0]  change_pipe;
    expected_t   expected;
    logic [31:0] lfsr_state;
    int          error_count  = 0;
    int          check_count  = 0;
    int          failed_tests = 0;
    int          cycle_count  = 0;

    decoding_graph decoding_graph_inst (
        .clk             (clk),
        .reset           (reset),
        .measurements_i  (measurements),
        .stage_i         (stage),
        .weight_wr_i     (weight_wr),
        .weight_wr_data_i(weight_wr_data),
        .busy_o          (busy),
        .link_grown_o    (link_grown)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic random_round(output logic [GRID_WIDTH_X-1:0] round);
        for (int i = 0; i < GRID_WIDTH_X; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            round[i]   = lfsr_state[0];
        end
    endtask

    // Unit at one end of link n in round k, -1 where that end is a boundary
    function automatic int link_end(input link_family_e family, input int n, input int k,
                                    input bit far_end);
        int row;
        int base;
        int near;
        int far;
        row  = n + 1;
        base = k * GRID_WIDTH_X;
        case (family)
            LINK_NS: begin
                near = base + row - 1;
                far  = (row % 2 == 1) ? base + row : -1;
            end
            LINK_EW: begin
                if (n == GRID_WIDTH_X - 1) begin
                    near = base + n;  // East boundary
                    far  = -1;
                end else begin
                    near = base + row - 1;
                    far  = (row % 2 == 0) ? base + row : -1;
                end
            end
            default: begin
                near = base + n;
                far  = (k == 0) ? -1 : base + n - GRID_WIDTH_X;  // Round 0 sits on a boundary
            end
        endcase
        return far_end ? far : near;
    endfunction

    function automatic int links_per_round(input link_family_e family);
        return (family == LINK_NS) ? GRID_WIDTH_X - 1 : GRID_WIDTH_X;
    endfunction

    function automatic int grown_offset(input link_family_e family);
        return (family == LINK_NS) ? EW_LINKS + UD_LINKS : (family == LINK_EW) ? UD_LINKS : 0;
    endfunction

    function automatic int family_weight(input weight_cfg_t w, input link_family_e family);
        return (family == LINK_NS) ? int'(w.ns) : (family == LINK_EW) ? int'(w.ew) : int'(w.ud);
    endfunction

    function automatic expected_t reference_outputs(input ref_state_t st);
        expected_t           result;
        link_family_e        family;
        logic [PU_COUNT-1:0] open_unit;  // Touches a link that is not grown
        int                  a;
        int                  b;
        int                  ends;
        int                  growth;
        int                  weight;
        result    = '0;
        open_unit = '0;
        for (int f = 0; f < 3; f++) begin
            family = link_family_e'(f);
            weight = family_weight(st.weights, family);
            for (int k = 0; k < GRID_WIDTH_U; k++) begin
                for (int n = 0; n < links_per_round(family); n++) begin
                    a    = link_end(family, n, k, 1'b0);
                    b    = link_end(family, n, k, 1'b1);
                    ends = int'(st.defects[a]);
                    if (b >= 0) begin
                        ends = ends + int'(st.defects[b]);
                    end
                    growth = int'(st.grows) * ends;
                    growth = (growth > weight) ? weight : growth;
                    result.grown[grown_offset(family) + n + k * links_per_round(family)] =
                        (growth >= weight);
                    if (growth < weight) begin
                        open_unit[a] = 1'b1;
                        if (b >= 0) begin
                            open_unit[b] = 1'b1;
                        end
                    end
                end
            end
        end
        result.busy = st.defects & open_unit;
        return result;
    endfunction

    task automatic compare(input string what, input logic [63:0] got,
                           input logic [63:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // Tracks the registered stage and what it does at the next edge
    always @(posedge clk) begin
        if (reset) begin
            ref_state.defects    <= '0;
            ref_state.weights.ns <= 4'd2;
            ref_state.weights.ew <= 4'd2;
            ref_state.weights.ud <= 4'd2;
            ref_state.grows      <= '0;
            ref_stage_q          <= STAGE_IDLE;
            change_pipe          <= '0;
        end else begin
            change_pipe <= {change_pipe[0], stage != ref_stage_q};
            ref_stage_q <= stage;
            case (ref_stage_q)
                STAGE_MEASUREMENT_LOADING: begin
                    ref_state.defects <= {measurements, ref_state.defects[PU_COUNT-1:GRID_WIDTH_X]};
                    ref_state.grows   <= '0;
                end
                STAGE_GROW: ref_state.grows <= ref_state.grows + 8'd1;
                STAGE_IDLE: begin
                    if (weight_wr) begin
                        case (weight_wr_data.family)
                            LINK_NS: ref_state.weights.ns <= weight_wr_data.value;
                            LINK_EW: ref_state.weights.ew <= weight_wr_data.value;
                            LINK_UD: ref_state.weights.ud <= weight_wr_data.value;
                            default: ;
                        endcase
                    end
                end
                default: ;
            endcase
        end
    end

    // Results of a stage change are visible two edges later
    always @(negedge clk) begin
        if (!reset && change_pipe[1]) begin
            expected = reference_outputs(ref_state);
            compare("busy_o", 64'(busy), 64'(expected.busy));
            compare("link_grown_o", 64'(link_grown), 64'(expected.grown));
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic drive_cycle(input stage_e next_stage, input logic [GRID_WIDTH_X-1:0] round,
                               input logic wr, input weight_write_t wr_data);
        @(posedge clk);
        #1;
        stage          = next_stage;
        measurements   = round;
        weight_wr      = wr;
        weight_wr_data = wr_data;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) drive_cycle(STAGE_IDLE, '0, 1'b0, '0);
    endtask

    // Measurements trail the stage by one cycle
    task automatic load_rounds(input int count);
        logic [GRID_WIDTH_X-1:0] round;
        drive_cycle(STAGE_MEASUREMENT_LOADING, '0, 1'b0, '0);
        for (int r = 0; r < count; r++) begin
            random_round(round);
            drive_cycle((r < count - 1) ? STAGE_MEASUREMENT_LOADING : STAGE_IDLE, round, 1'b0, '0);
        end
        idle_cycles(SETTLE_CYCLES);
    endtask

    task automatic grow_cycles(input int count);
        repeat (count) drive_cycle(STAGE_GROW, '0, 1'b0, '0);
        idle_cycles(SETTLE_CYCLES);
    endtask

    function automatic weight_write_t weight_word(input link_family_e family,
                                                  input logic [WEIGHT_WIDTH_MAX-1:0] value);
        weight_write_t word;
        word.family = family;
        word.value  = value;
        return word;
    endfunction

    task automatic report_test(input int number, input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %0d %s: passed", number, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", number, name,
                     error_count - errors_before);
        end
    endtask

    initial begin
        int errors_before;
        reset          = 1'b1;
        stage          = STAGE_GROW;  // Live stage while reset clears the stage register
        measurements   = '0;
        weight_wr      = 1'b0;
        weight_wr_data = '0;
        lfsr_state     = LFSR_SEED;
        repeat (RESET_LEN) @(posedge clk);
        #1;
        reset = 1'b0;
        stage = STAGE_IDLE;

        errors_before = error_count;
        @(negedge clk);
        compare("busy_o after reset", 64'(busy), 64'd0);
        compare("link_grown_o after reset", 64'(link_grown), 64'd0);
        report_test(1, "reset state", errors_before);

        errors_before = error_count;
        load_rounds(GRID_WIDTH_U);
        report_test(2, "round loading", errors_before);

        errors_before = error_count;
        grow_cycles(2);
        report_test(3, "growth at default weights", errors_before);

        errors_before = error_count;
        load_rounds(GRID_WIDTH_U);  // Clear growth before the weights change
        drive_cycle(STAGE_IDLE, '0, 1'b1, weight_word(LINK_NS, 4'd1));
        drive_cycle(STAGE_IDLE, '0, 1'b1, weight_word(LINK_EW, 4'd3));
        drive_cycle(STAGE_IDLE, '0, 1'b1, weight_word(LINK_UD, 4'd2));
        grow_cycles(3);
        report_test(4, "per-family weights", errors_before);

        errors_before = error_count;
        drive_cycle(STAGE_GROW, '0, 1'b0, '0);
        drive_cycle(STAGE_GROW, '0, 1'b1, weight_word(LINK_NS, 4'd3));  // Must be dropped
        load_rounds(1);
        grow_cycles(1);
        report_test(5, "write during grow and reload", errors_before);

        $display("5 tests, %0d failed, %0d checks, %0d errors", failed_tests, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: decoding_graph.f
src/decoding_graph_pkg.sv
src/graph_config.sv
src/processing_unit.sv
src/neighbor_link.sv
src/decoding_graph.sv
dv/decoding_graph_chk.sv
dv/decoding_graph_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= decoding_graph_tb
FILELIST  ?= decoding_graph.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test FAILED
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
